/* build.f */
common/xbus_pkg.sv
io/kbd_receiver.sv
io/mouse_quadrature.sv
io/io_timers.sv
io/xbus_io.sv
hdl/scan_fifo.sv
hdl/xbus_io_board.sv
verif/xbus_io_asserts.sv
verif/tb_xbus_io.sv

/* Bender.yml */
package:
  name: xbus_io_board

sources:
  - common/xbus_pkg.sv
  - io/kbd_receiver.sv
  - io/mouse_quadrature.sv
  - io/io_timers.sv
  - io/xbus_io.sv
  - hdl/scan_fifo.sv
  - hdl/xbus_io_board.sv
  - target: test
    files:
      - verif/xbus_io_asserts.sv
      - verif/tb_xbus_io.sv

/* verif/tb_xbus_io.sv */
/*
 * Testbench for the xbus I/O board. Random bus traffic, keyboard scans
 * and mouse steps, all checked against a register model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_xbus_io;
   import xbus_pkg::*;

   localparam int ack_timeout = 8;

   logic                   clk = 1'b0;
   logic                   reset;
   logic [xbus_addr_w-1:0] addr;
   logic [xbus_data_w-1:0] datain;
   logic                   req;
   logic                   write;
   logic                   kbd_bit_valid;
   logic                   kbd_bit;
   logic                   mouse_xa;
   logic                   mouse_xb;
   logic                   mouse_ya;
   logic                   mouse_yb;
   logic [2:0]             mouse_buttons;
   logic [xbus_data_w-1:0] dataout;
   logic                   ack;
   logic                   decode;
   logic                   interrupt;

   logic [31:0]            rng_state = 32'h5a903939;
   int unsigned            cycle_count = 0;
   int unsigned            start_cycle;

   // Register model.
   logic [31:0]            scan_q[$];
   logic [mouse_pos_w-1:0] x_model;
   logic [mouse_pos_w-1:0] y_model;
   logic [1:0]             x_phase;
   logic [1:0]             y_phase;
   logic [2:0]             btn_model;
   logic                   moved_model;
   logic [3:0]             csr_model;

   xbus_io_board u_dut (
      .clk(clk), .reset(reset),
      .addr(addr), .datain(datain), .req(req), .write(write),
      .kbd_bit_valid(kbd_bit_valid), .kbd_bit(kbd_bit),
      .mouse_xa(mouse_xa), .mouse_xb(mouse_xb),
      .mouse_ya(mouse_ya), .mouse_yb(mouse_yb),
      .mouse_buttons(mouse_buttons),
      .dataout(dataout), .ack(ack), .decode(decode), .interrupt(interrupt)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   // -------------------------------------------------------------------------
   // Helpers.

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // The board answers the 64 words from the window base upward.
   function automatic logic in_window(input logic [xbus_addr_w-1:0] a);
      return (a >= iob_base) && (a <= iob_base + 22'd63);
   endfunction

   // Gray order 00, 01, 11, 10 counts up.
   function automatic logic [1:0] gray_forward(input logic [1:0] p);
      case (p)
         2'b00:   return 2'b01;
         2'b01:   return 2'b11;
         2'b11:   return 2'b10;
         default: return 2'b00;
      endcase
   endfunction

   function automatic logic [1:0] gray_reverse(input logic [1:0] p);
      case (p)
         2'b00:   return 2'b10;
         2'b10:   return 2'b11;
         2'b11:   return 2'b01;
         default: return 2'b00;
      endcase
   endfunction

   function automatic logic [31:0] expected_csr();
      logic [31:0] v;
      v                      = '0;
      v[3:0]                 = csr_model;
      v[csr_mouse_moved_bit] = moved_model;
      v[csr_key_ready_bit]   = (scan_q.size() != 0);
      return v;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Simulation stopped after an error.");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
                  $time, msg, actual, expected);
         abort_run("Stopping at the first mismatch.");
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // -------------------------------------------------------------------------
   // Bus master. One request, then req low for at least one edge.

   task automatic bus_cycle(input logic [xbus_addr_w-1:0] a, input logic w,
                            input logic [31:0] d, output logic [31:0] rdata);
      int   cycles;
      logic hit;
      hit = in_window(a);
      tick();
      addr   = a;
      write  = w;
      datain = d;
      req    = 1'b1;
      cycles = 0;
      do
      begin
         tick();
         cycles++;
         if (cycles == 1)
            start_cycle = cycle_count;
         check_value(decode, hit, "decode against the window rule");
      end
      while (!ack && cycles < ack_timeout);
      if (hit && !ack)
         abort_run("Timeout: no ack for an address inside the window.");
      else if (hit)
      begin
         check_value(cycles, 2, "ack delay in cycles");
         // Keep req for one more edge, ack has to stay up.
         tick();
         check_value(ack, 1'b1, "ack held while req stays high");
      end
      else
         check_value(ack, 1'b0, "ack for an address outside the window");
      rdata = dataout;
      req   = 1'b0;
   endtask

   task automatic bus_read(input logic [xbus_addr_w-1:0] a, output logic [31:0] rdata);
      bus_cycle(a, 1'b0, 32'h0, rdata);
   endtask

   task automatic bus_write(input logic [xbus_addr_w-1:0] a, input logic [31:0] d);
      logic [31:0] discard;
      bus_cycle(a, 1'b1, d, discard);
   endtask

   task automatic check_interrupt();
      logic expected;
      expected = ((scan_q.size() != 0) && csr_model[csr_kbd_int_en_bit]) ||
                 (moved_model && csr_model[csr_mouse_int_en_bit]);
      check_value(interrupt, expected, "interrupt level");
   endtask

   task automatic check_csr();
      logic [31:0] r;
      bus_read(iob_csr, r);
      check_value(r, expected_csr(), "CSR read");
      check_interrupt();
   endtask

   // -------------------------------------------------------------------------
   // Behaviors.

   task automatic decode_test();
      logic [31:0]            rnd;
      logic [31:0]            r;
      logic [xbus_addr_w-1:0] a;
      rnd = next_rand();
      if (rnd[31])
         a = {iob_base[xbus_addr_w-1:6], rnd[5:0]};
      else
      begin
         a = rnd[xbus_addr_w-1:0];
         if (in_window(a))
            a = a ^ 22'h100000;
      end
      bus_read(a, r);
   endtask

   // One strobe per bit, LSB first, then the receiver and FIFO settle.
   task automatic send_scan(input logic [31:0] scan);
      for (int i = 0; i < 32; i++)
      begin
         tick();
         kbd_bit_valid = 1'b1;
         kbd_bit       = scan[i];
         tick();
         kbd_bit_valid = 1'b0;
      end
      repeat (3) tick();
      if (scan_q.size() < scan_fifo_depth)
         scan_q.push_back(scan);
   endtask

   task automatic read_scan();
      logic [31:0] head;
      logic [31:0] r;
      head = scan_q.pop_front();
      bus_read(iob_kbd_lo, r);
      check_value(r, {16'h0, head[15:0]}, "kbd_lo read");
      bus_read(iob_kbd_hi, r);
      check_value(r, {16'h0, head[31:16]}, "kbd_hi read");
      check_csr();
   endtask

   task automatic mouse_step(input logic y_axis, input logic forward, input logic [2:0] btns);
      logic [1:0] p;
      p = y_axis ? y_phase : x_phase;
      p = forward ? gray_forward(p) : gray_reverse(p);
      tick();
      if (y_axis)
      begin
         y_phase              = p;
         y_model              = forward ? y_model + 1'b1 : y_model - 1'b1;
         {mouse_ya, mouse_yb} = p;
      end
      else
      begin
         x_phase              = p;
         x_model              = forward ? x_model + 1'b1 : x_model - 1'b1;
         {mouse_xa, mouse_xb} = p;
      end
      mouse_buttons = btns;
      btn_model     = btns;
      moved_model   = 1'b1;
      repeat (4) tick();
   endtask

   task automatic check_mouse();
      logic [31:0] r;
      bus_read(iob_mouse_x, r);
      check_value(r, {16'h0, y_phase, x_phase, x_model}, "mouse_x read");
      bus_read(iob_mouse_y, r);
      check_value(r, {17'h0, btn_model, y_model}, "mouse_y read");
      moved_model = 1'b0;
      check_csr();
   endtask

   task automatic check_timers();
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] t0;
      logic [31:0] t1;
      int unsigned c0;
      int unsigned n;
      int          diff;
      bus_read(iob_usec_lo, lo);
      c0 = start_cycle;
      bus_read(iob_usec_hi, hi);
      t0 = {hi[15:0], lo[15:0]};
      n  = 50 + next_rand() % 200;
      repeat (n) tick();
      bus_read(iob_usec_lo, lo);
      diff = -int'((start_cycle - c0) / cycles_per_usec);
      bus_read(iob_usec_hi, hi);
      t1   = {hi[15:0], lo[15:0]};
      diff = diff + int'(t1 - t0);
      check_value(diff >= -1 && diff <= 1, 1'b1, "microsecond count against elapsed cycles");
      bus_read(iob_hz60, lo);
      if (t1 < usec_per_tick)
         check_value(lo, 32'h0, "60 Hz count inside the first tick period");
   endtask

   // Listed registers other than beep move to the unlisted 060-077 range.
   task automatic unlisted_test();
      logic [31:0]            rnd;
      logic [31:0]            r;
      logic [5:0]             off;
      logic [xbus_addr_w-1:0] a;
      rnd = next_rand();
      off = rnd[5:0];
      if ((off >= 6'o40 && off <= 6'o52) && off != 6'o44 && off != 6'o46 && off != 6'o47)
         off = off ^ 6'o20;
      a = {iob_base[xbus_addr_w-1:6], off};
      bus_read(a, r);
      check_value(r, 32'h0, "read of beep or unlisted address");
      bus_write(a, next_rand());
      check_csr();
   endtask

   // -------------------------------------------------------------------------
   // Main sequence.

   initial
   begin
      logic [31:0] rnd;
      reset         = 1'b1;
      addr          = '0;
      datain        = '0;
      req           = 1'b0;
      write         = 1'b0;
      kbd_bit_valid = 1'b0;
      kbd_bit       = 1'b0;
      mouse_xa      = 1'b0;
      mouse_xb      = 1'b0;
      mouse_ya      = 1'b0;
      mouse_yb      = 1'b0;
      mouse_buttons = 3'b000;
      x_model       = '0;
      y_model       = '0;
      x_phase       = 2'b00;
      y_phase       = 2'b00;
      btn_model     = 3'b000;
      moved_model   = 1'b0;
      csr_model     = 4'h0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      // Decode runs first, while the FIFO is empty and nothing has moved.
      repeat (40) decode_test();

      // A kbd_hi read of the empty FIFO must leave it empty.
      bus_read(iob_kbd_hi, rnd);
      check_csr();

      repeat (6)
      begin
         send_scan(next_rand());
         check_csr();
         read_scan();
      end

      // One scan more than the FIFO holds.
      for (int i = 0; i < 5; i++)
         send_scan(next_rand());
      check_csr();
      while (scan_q.size() != 0)
         read_scan();

      repeat (40)
      begin
         rnd = next_rand();
         mouse_step(rnd[0], rnd[1], rnd[7:5]);
         if (rnd[4:2] == 3'd0)
         begin
            check_csr();
            check_mouse();
         end
      end
      check_csr();
      check_mouse();

      // CSR writes mixed with pending keyboard and mouse events.
      repeat (16)
      begin
         rnd = next_rand();
         bus_write(iob_csr, rnd);
         csr_model = rnd[3:0];
         check_csr();
         if (rnd[8])
            send_scan(next_rand());
         else
            mouse_step(rnd[9], rnd[10], rnd[13:11]);
         check_csr();
         if (scan_q.size() >= 3)
            read_scan();
         if (rnd[14])
            check_mouse();
      end

      repeat (3) check_timers();
      repeat (16) unlisted_test();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/xbus_io_asserts.sv */
/*
 * Bound checks for the xbus I/O board. Covers the ack handshake of the
 * register block and the pointer behavior of the scan FIFO.
 */
`timescale 1ns/1ps
`default_nettype none

module xbus_io_asserts #(
   parameter int ptr_w = 2
) (
   input wire logic             clk,
   input wire logic             reset,
   input wire logic             req,
   input wire logic             decode,
   input wire logic             ack,
   input wire logic             push,
   input wire logic             pop,
   input wire logic             empty,
   input wire logic [ptr_w-1:0] rd_ptr,
   input wire logic [ptr_w-1:0] wr_ptr
);

   // -------------------------------------------------------------------------
   // Bus handshake.
   ack_follows_decode: assert property (@(posedge clk) disable iff (reset)
      ack |-> $past(decode, 2))
      else $error("ack high without decode two cycles earlier");

   // Req must have been held through the whole ack delay.
   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> req && $past(req) && $past(req, 2))
      else $error("ack rose without req held through the ack delay");

   // -------------------------------------------------------------------------
   // FIFO pointers on a pop of an empty FIFO.
   empty_pop_rd_ptr: assert property (@(posedge clk) disable iff (reset)
      (pop && empty) |=> (rd_ptr == $past(rd_ptr)))
      else $error("read pointer moved on a pop of an empty FIFO");

   empty_pop_wr_ptr: assert property (@(posedge clk) disable iff (reset)
      (pop && empty && !push) |=> (wr_ptr == $past(wr_ptr)))
      else $error("write pointer moved on a pop of an empty FIFO");

endmodule

// Handshake checks on the register block, FIFO inputs tied off.
bind xbus_io xbus_io_asserts u_asserts (
   .clk(clk), .reset(reset),
   .req(req), .decode(decode), .ack(ack),
   .push(1'b0), .pop(1'b0), .empty(1'b1),
   .rd_ptr('0), .wr_ptr('0)
);

// Pointer checks on the FIFO, bus inputs tied off.
bind scan_fifo xbus_io_asserts #(.ptr_w(ptr_w)) u_asserts (
   .clk(clk), .reset(reset),
   .req(1'b0), .decode(1'b0), .ack(1'b0),
   .push(push), .pop(pop), .empty(empty),
   .rd_ptr(rd_ptr), .wr_ptr(wr_ptr)
);

`default_nettype wire

/* hdl/xbus_io_board.sv */
/*
 * xbus I/O board top level. Connects the keyboard receiver, scan FIFO,
 * mouse decoder and timers to the bus register block.
 */
`timescale 1ns/1ps
`default_nettype none

module xbus_io_board (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic [xbus_pkg::xbus_addr_w-1:0] addr,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] datain,
   input  wire logic                             req,
   input  wire logic                             write,
   input  wire logic                             kbd_bit_valid,
   input  wire logic                             kbd_bit,
   input  wire logic                             mouse_xa,
   input  wire logic                             mouse_xb,
   input  wire logic                             mouse_ya,
   input  wire logic                             mouse_yb,
   input  wire logic [2:0]                       mouse_buttons,
   output logic      [xbus_pkg::xbus_data_w-1:0] dataout,
   output logic                                  ack,
   output logic                                  decode,
   output logic                                  interrupt
);
   import xbus_pkg::*;

   logic                   scan_valid;
   logic [xbus_data_w-1:0] scan_data;
   logic [xbus_data_w-1:0] fifo_head;
   logic                   fifo_empty;
   logic                   fifo_pop;
   logic [mouse_pos_w-1:0] x_pos;
   logic [mouse_pos_w-1:0] y_pos;
   logic [1:0]             raw_x;
   logic [1:0]             raw_y;
   logic [2:0]             buttons;
   logic                   mouse_moved_pulse;
   logic [xbus_data_w-1:0] usec_count;
   logic [xbus_data_w-1:0] hz60_count;

   kbd_receiver u_kbd_receiver (
      .clk(clk), .reset(reset),
      .kbd_bit_valid(kbd_bit_valid), .kbd_bit(kbd_bit),
      .scan_valid(scan_valid), .scan_data(scan_data)
   );

   // Overflow has no register bit on this board.
   scan_fifo u_scan_fifo (
      .clk(clk), .reset(reset),
      .push(scan_valid), .push_data(scan_data), .pop(fifo_pop),
      .head_data(fifo_head), .empty(fifo_empty), .overflow()
   );

   mouse_quadrature u_mouse_quadrature (
      .clk(clk), .reset(reset),
      .xa(mouse_xa), .xb(mouse_xb), .ya(mouse_ya), .yb(mouse_yb),
      .buttons_in(mouse_buttons),
      .x_pos(x_pos), .y_pos(y_pos), .raw_x(raw_x), .raw_y(raw_y),
      .buttons(buttons), .moved(mouse_moved_pulse)
   );

   io_timers u_io_timers (
      .clk(clk), .reset(reset),
      .usec_count(usec_count), .hz60_count(hz60_count)
   );

   xbus_io u_xbus_io (
      .clk(clk), .reset(reset),
      .addr(addr), .datain(datain), .req(req), .write(write),
      .fifo_head(fifo_head), .fifo_empty(fifo_empty),
      .x_pos(x_pos), .y_pos(y_pos), .raw_x(raw_x), .raw_y(raw_y),
      .buttons(buttons), .mouse_moved_pulse(mouse_moved_pulse),
      .usec_count(usec_count), .hz60_count(hz60_count),
      .dataout(dataout), .ack(ack), .decode(decode),
      .interrupt(interrupt), .fifo_pop(fifo_pop)
   );

endmodule

`default_nettype wire

/* hdl/scan_fifo.sv */
/*
 * Keyboard scan FIFO. Circular buffer with a show-ahead head word;
 * pushes into a full FIFO are dropped and flagged as overflow.
 */
`timescale 1ns/1ps
`default_nettype none

module scan_fifo #(
   parameter int depth = xbus_pkg::scan_fifo_depth
) (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             push,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] push_data,
   input  wire logic                             pop,
   output logic      [xbus_pkg::xbus_data_w-1:0] head_data,
   output logic                                  empty,
   output logic                                  overflow
);
   import xbus_pkg::*;

   localparam int ptr_w   = $clog2(depth);
   localparam int count_w = $clog2(depth + 1);

   logic [xbus_data_w-1:0] mem [depth];
   logic [ptr_w-1:0]       rd_ptr;
   logic [ptr_w-1:0]       wr_ptr;
   logic [count_w-1:0]     count;
   logic                   full;
   logic                   do_push;
   logic                   do_pop;

   assign full    = (count == count_w'(depth));
   assign empty   = (count == '0);
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign head_data = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   // Pointers wrap at depth, which need not be a power of two.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + count_w'(do_push) - count_w'(do_pop);
         // Sticky until reset.
         if (push && full)
            overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* io/xbus_io.sv */
/*
 * xbus register block of the I/O board. Decodes the board window,
 * forms the delayed ack, reads every register and holds the CSR.
 */
`timescale 1ns/1ps
`default_nettype none

module xbus_io (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic [xbus_pkg::xbus_addr_w-1:0] addr,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] datain,
   input  wire logic                           req,
   input  wire logic                           write,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] fifo_head,
   input  wire logic                           fifo_empty,
   input  wire logic [xbus_pkg::mouse_pos_w-1:0] x_pos,
   input  wire logic [xbus_pkg::mouse_pos_w-1:0] y_pos,
   input  wire logic [1:0]                     raw_x,
   input  wire logic [1:0]                     raw_y,
   input  wire logic [2:0]                     buttons,
   input  wire logic                           mouse_moved_pulse,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] usec_count,
   input  wire logic [xbus_pkg::xbus_data_w-1:0] hz60_count,
   output logic      [xbus_pkg::xbus_data_w-1:0] dataout,
   output logic                                ack,
   output logic                                decode,
   output logic                                interrupt,
   output logic                                fifo_pop
);
   import xbus_pkg::*;

   logic [1:0]             ack_stage;
   logic                   req_q;
   logic                   start;
   logic                   rd_start;
   logic [csr_wr_bits-1:0] csr_en;
   logic                   mouse_moved;
   logic [xbus_data_w-1:0] csr_word;
   logic [xbus_data_w-1:0] read_word;

   // -------------------------------------------------------------------------
   // Window decode and ack delay.

   assign decode = req & (addr[xbus_addr_w-1:6] == iob_base[xbus_addr_w-1:6]);

   // Stage 1 also needs decode so a new request right after a gap
   // does not inherit the old ack.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_stage <= '0;
         req_q     <= 1'b0;
      end
      else
      begin
         ack_stage[0] <= decode;
         ack_stage[1] <= ack_stage[0] & decode;
         req_q        <= req;
      end
   end

   assign ack = ack_stage[1] & decode;

   // First cycle of a request; all side effects happen here.
   assign start    = decode & ~req_q;
   assign rd_start = start & ~write;

   assign fifo_pop = rd_start & (addr == iob_kbd_hi);

   // -------------------------------------------------------------------------
   // Read multiplexer.

   always_comb
   begin
      csr_word                      = '0;
      csr_word[csr_wr_bits-1:0]     = csr_en;
      csr_word[csr_mouse_moved_bit] = mouse_moved;
      csr_word[csr_key_ready_bit]   = ~fifo_empty;
   end

   always_comb
   begin
      case (addr)
         iob_kbd_lo:  read_word = {16'b0, fifo_head[15:0]};
         iob_kbd_hi:  read_word = {16'b0, fifo_head[31:16]};
         iob_mouse_y: read_word = {17'b0, buttons, y_pos};
         iob_mouse_x: read_word = {16'b0, raw_y, raw_x, x_pos};
         iob_csr:     read_word = csr_word;
         iob_usec_lo: read_word = {16'b0, usec_count[15:0]};
         iob_usec_hi: read_word = {16'b0, usec_count[31:16]};
         iob_hz60:    read_word = hz60_count;
         // Beep and unlisted addresses read as zero.
         default:     read_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (rd_start)
         dataout <= read_word;
   end

   // -------------------------------------------------------------------------
   // CSR, mouse-moved flag and interrupt.

   always_ff @(posedge clk)
   begin
      if (reset)
         csr_en <= '0;
      else if (start && write && addr == iob_csr)
         csr_en <= datain[csr_wr_bits-1:0];
   end

   // Set wins over the clear from a mouse_y read.
   always_ff @(posedge clk)
   begin
      if (reset)
         mouse_moved <= 1'b0;
      else if (mouse_moved_pulse)
         mouse_moved <= 1'b1;
      else if (rd_start && addr == iob_mouse_y)
         mouse_moved <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else
         interrupt <= (~fifo_empty & csr_en[csr_kbd_int_en_bit]) |
                      (mouse_moved & csr_en[csr_mouse_int_en_bit]);
   end

endmodule

`default_nettype wire

/* io/io_timers.sv */
/*
 * Board timers. A cycle prescaler makes a microsecond tick that runs
 * the microsecond counter and, through a second prescaler, the 60 Hz count.
 */
`timescale 1ns/1ps
`default_nettype none

module io_timers (
   input  wire logic                             clk,
   input  wire logic                             reset,
   output logic [xbus_pkg::xbus_data_w-1:0]      usec_count,
   output logic [xbus_pkg::xbus_data_w-1:0]      hz60_count
);
   import xbus_pkg::*;

   localparam int usec_pre_w = $clog2(cycles_per_usec);
   localparam int tick_pre_w = $clog2(usec_per_tick);

   logic [usec_pre_w-1:0] usec_pre;
   logic [tick_pre_w-1:0] tick_pre;
   logic                  usec_tick;
   logic                  hz60_tick;

   assign usec_tick = (usec_pre == usec_pre_w'(cycles_per_usec - 1));
   assign hz60_tick = usec_tick & (tick_pre == tick_pre_w'(usec_per_tick - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         usec_pre   <= '0;
         tick_pre   <= '0;
         usec_count <= '0;
         hz60_count <= '0;
      end
      else
      begin
         usec_pre <= usec_tick ? '0 : usec_pre + 1'b1;

         if (usec_tick)
         begin
            usec_count <= usec_count + 1'b1;
            tick_pre   <= hz60_tick ? '0 : tick_pre + 1'b1;
         end

         if (hz60_tick)
            hz60_count <= hz60_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* io/mouse_quadrature.sv */
/*
 * Mouse quadrature decoder. Tracks X and Y positions from the raw
 * phase pairs, samples the buttons and strobes on every counted step.
 */
`timescale 1ns/1ps
`default_nettype none

module mouse_quadrature (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             xa,
   input  wire logic                             xb,
   input  wire logic                             ya,
   input  wire logic                             yb,
   input  wire logic [2:0]                       buttons_in,
   output logic      [xbus_pkg::mouse_pos_w-1:0] x_pos,
   output logic      [xbus_pkg::mouse_pos_w-1:0] y_pos,
   output logic      [1:0]                       raw_x,
   output logic      [1:0]                       raw_y,
   output logic      [2:0]                       buttons,
   output logic                                  moved
);
   import xbus_pkg::*;

   logic [1:0] x_prev;
   logic [1:0] y_prev;
   logic [1:0] x_step;
   logic [1:0] y_step;

   // Returns {forward, reverse} for one pair transition.
   // Forward order is 00, 01, 11, 10; a double-bit jump gives 00.
   function automatic logic [1:0] quad_step(input logic [1:0] prev, input logic [1:0] cur);
      case ({prev, cur})
         4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: quad_step = 2'b10;
         4'b01_00, 4'b11_01, 4'b10_11, 4'b00_10: quad_step = 2'b01;
         default:                                 quad_step = 2'b00;
      endcase
   endfunction

   assign x_step = quad_step(x_prev, raw_x);
   assign y_step = quad_step(y_prev, raw_y);

   // Phase registers; raw_* is the current pair, *_prev the one before.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         raw_x  <= 2'b00;
         raw_y  <= 2'b00;
         x_prev <= 2'b00;
         y_prev <= 2'b00;
      end
      else
      begin
         raw_x  <= {xa, xb};
         raw_y  <= {ya, yb};
         x_prev <= raw_x;
         y_prev <= raw_y;
      end
   end

   // Position counters wrap at the counter width.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         x_pos   <= '0;
         y_pos   <= '0;
         moved   <= 1'b0;
         buttons <= 3'b000;
      end
      else
      begin
         x_pos   <= x_pos + {{(mouse_pos_w-1){x_step[0]}}, |x_step};
         y_pos   <= y_pos + {{(mouse_pos_w-1){y_step[0]}}, |y_step};
         moved   <= |{x_step, y_step};
         buttons <= buttons_in;
      end
   end

endmodule

`default_nettype wire

/* io/kbd_receiver.sv */
/*
 * Keyboard receiver. Shifts serial bits in LSB first and strobes
 * out one 32-bit scan for every 32 bits received.
 */
`timescale 1ns/1ps
`default_nettype none

module kbd_receiver (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             kbd_bit_valid,
   input  wire logic                             kbd_bit,
   output logic                                  scan_valid,
   output logic [xbus_pkg::xbus_data_w-1:0]      scan_data
);
   import xbus_pkg::*;

   logic [xbus_data_w-1:0] shift_reg;
   logic [4:0]             bit_count;

   // New bits enter at the top, so the first bit lands in bit 0.
   always_ff @(posedge clk)
   begin
      if (kbd_bit_valid)
         shift_reg <= {kbd_bit, shift_reg[xbus_data_w-1:1]};
   end

   // Counter wraps after bit 31 to start the next scan.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bit_count  <= '0;
         scan_valid <= 1'b0;
      end
      else
      begin
         scan_valid <= kbd_bit_valid & (bit_count == 5'd31);
         if (kbd_bit_valid)
            bit_count <= bit_count + 5'd1;
      end
   end

   // Full word sits in the shift register during the strobe.
   assign scan_data = shift_reg;

endmodule

`default_nettype wire

/* common/xbus_pkg.sv */
/*
 * Shared definitions for the xbus I/O board: bus widths, register
 * addresses inside the board window, CSR bit positions and prescales.
 */
`default_nettype none

package xbus_pkg;

   // -------------------------------------------------------------------------
   // Bus widths.
   localparam int xbus_addr_w = 22;
   localparam int xbus_data_w = 32;

   // -------------------------------------------------------------------------
   // Board window, decoded on address bits 21 to 6.
   localparam logic [xbus_addr_w-1:0] iob_base = 22'o17772000;

   localparam logic [xbus_addr_w-1:0] iob_kbd_lo  = 22'o17772040;
   localparam logic [xbus_addr_w-1:0] iob_kbd_hi  = 22'o17772041;
   localparam logic [xbus_addr_w-1:0] iob_mouse_y = 22'o17772042;
   localparam logic [xbus_addr_w-1:0] iob_mouse_x = 22'o17772043;
   localparam logic [xbus_addr_w-1:0] iob_beep    = 22'o17772044;
   localparam logic [xbus_addr_w-1:0] iob_csr     = 22'o17772045;
   localparam logic [xbus_addr_w-1:0] iob_usec_lo = 22'o17772050;
   localparam logic [xbus_addr_w-1:0] iob_usec_hi = 22'o17772051;
   localparam logic [xbus_addr_w-1:0] iob_hz60    = 22'o17772052;

   // -------------------------------------------------------------------------
   // Keyboard/mouse CSR layout.
   localparam int csr_key_ready_bit    = 5;
   localparam int csr_mouse_moved_bit  = 4;
   localparam int csr_mouse_int_en_bit = 1;
   localparam int csr_kbd_int_en_bit   = 0;
   // Bits 3 to 0 are writable.
   localparam int csr_wr_bits = 4;

   // -------------------------------------------------------------------------
   // Block sizes and timer prescales.
   localparam int scan_fifo_depth = 4;
   localparam int mouse_pos_w     = 12;
   localparam int cycles_per_usec = 10;
   localparam int usec_per_tick   = 16667;

endpackage

`default_nettype wire
